// File: hdl/pm_tile_consts.svh
`ifndef PM_TILE_CONSTS_SVH
`define PM_TILE_CONSTS_SVH

// noc packet fields
`define NOC_ADDR_SIZE     32
`define NOC_DATA_SIZE     64
`define NOC_CHIPID_SIZE   8
`define NOC_MODID_SIZE    8
`define NOC_MODE_SIZE     4

// scratchpad of 512 64-bit words
`define SPM_ADDR_SIZE     9

// memory map, both regions span 4 KiB
`define REGION_OFFS_SIZE  12
`define SPM_START_ADDR    32'h0000_0000
`define CFG_START_ADDR    32'hF000_0000

// config register offsets
`define CFG_REG_CORE_EN   12'h000
`define CFG_REG_EXT_INT   12'h008
`define CFG_REG_DROP_CNT  12'h010

`endif

// File: hdl/pm_tile_pkg.sv
`include "pm_tile_consts.svh"

package pm_tile_pkg;

    // mode field of a noc packet, other codes are invalid
    typedef enum logic [`NOC_MODE_SIZE-1:0] {
        MODE_READ_REQ  = 0,
        MODE_WRITE     = 1,
        MODE_READ_RESP = 2
    } noc_mode_e;

    // which unit serves a request
    typedef enum logic {
        REGION_SPM,
        REGION_CFG
    } req_region_e;

endpackage

// File: hdl/noc_req_if.sv
`include "pm_tile_consts.svh"

interface noc_req_if;
    import pm_tile_pkg::*;

    logic                        valid;
    noc_mode_e                   mode;
    req_region_e                 region;
    logic [`NOC_ADDR_SIZE-1:0]   addr;
    logic [`NOC_DATA_SIZE-1:0]   data;
    logic [`NOC_CHIPID_SIZE-1:0] peer_chipid;  // requester
    logic [`NOC_MODID_SIZE-1:0]  peer_modid;

    modport src (
        output valid, mode, region, addr, data, peer_chipid, peer_modid
    );

    modport dst (
        input valid, mode, region, addr, data, peer_chipid, peer_modid
    );

endinterface

// File: hdl/spm.sv
`include "pm_tile_consts.svh"

module spm (
    input  logic                      clk_pm_i,
    input  logic                      en_i,
    input  logic                      we_i,
    input  logic [`SPM_ADDR_SIZE-1:0] addr_i,
    input  logic [`NOC_DATA_SIZE-1:0] wdata_i,
    output logic [`NOC_DATA_SIZE-1:0] rdata_o
);

    logic [`NOC_DATA_SIZE-1:0] mem [0:(1 << `SPM_ADDR_SIZE)-1];

    always_ff @(posedge clk_pm_i) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end
            rdata_o <= mem[addr_i];  // read first
        end
    end

    a_addr_known: assert property (@(posedge clk_pm_i)
        en_i |-> !$isunknown(addr_i));

endmodule

// File: hdl/tile_regfile.sv
`include "pm_tile_consts.svh"

module tile_regfile (
    input  logic                         clk_pm_i,
    input  logic                         reset_i,
    input  logic                         en_i,
    input  logic                         we_i,
    input  logic [`REGION_OFFS_SIZE-1:0] addr_i,
    input  logic [`NOC_DATA_SIZE-1:0]    wdata_i,
    output logic [`NOC_DATA_SIZE-1:0]    rdata_o,
    input  logic                         drop_i,
    output logic                         core_en_o,
    output logic [1:0]                   ext_int_o
);

    logic [31:0] drop_cnt;

    always_ff @(posedge clk_pm_i) begin
        if (reset_i) begin
            core_en_o <= 1'b0;
            ext_int_o <= 2'b00;
            drop_cnt  <= '0;
        end else begin
            if (en_i && we_i) begin
                case (addr_i)
                    `CFG_REG_CORE_EN: core_en_o <= wdata_i[0];
                    `CFG_REG_EXT_INT: ext_int_o <= wdata_i[1:0];
                    default: ;  // drop counter is read only
                endcase
            end
            if (drop_i && (drop_cnt != '1)) begin
                drop_cnt <= drop_cnt + 1'b1;  // saturates
            end
        end
    end

    always_ff @(posedge clk_pm_i) begin
        if (en_i) begin
            case (addr_i)
                `CFG_REG_CORE_EN:  rdata_o <= `NOC_DATA_SIZE'(core_en_o);
                `CFG_REG_EXT_INT:  rdata_o <= `NOC_DATA_SIZE'(ext_int_o);
                `CFG_REG_DROP_CNT: rdata_o <= `NOC_DATA_SIZE'(drop_cnt);
                default:           rdata_o <= '0;
            endcase
        end
    end

endmodule

// File: hdl/noc_rx_decode.sv
`include "pm_tile_consts.svh"

module noc_rx_decode #(
    parameter logic [`NOC_MODID_SIZE-1:0] HOME_MODID = '0
) (
    input  logic                        clk_pm_i,
    input  logic                        reset_i,
    input  logic                        hold_i,
    input  logic [`NOC_CHIPID_SIZE-1:0] home_chipid_i,
    input  logic                        rx_wrreq_i,
    input  logic [`NOC_MODE_SIZE-1:0]   rx_mode_i,
    input  logic [`NOC_ADDR_SIZE-1:0]   rx_addr_i,
    input  logic [`NOC_DATA_SIZE-1:0]   rx_data_i,
    input  logic [`NOC_CHIPID_SIZE-1:0] rx_src_chipid_i,
    input  logic [`NOC_MODID_SIZE-1:0]  rx_src_modid_i,
    input  logic [`NOC_CHIPID_SIZE-1:0] rx_trg_chipid_i,
    input  logic [`NOC_MODID_SIZE-1:0]  rx_trg_modid_i,
    noc_req_if.src                      req_o,
    output logic                        drop_o
);
    import pm_tile_pkg::*;

    logic tgt_hit;
    logic mode_ok;
    logic in_spm;
    logic in_cfg;
    logic accept;

    always_comb begin
        tgt_hit = (rx_trg_chipid_i == home_chipid_i) && (rx_trg_modid_i == HOME_MODID);
        mode_ok = (rx_mode_i == MODE_READ_REQ) || (rx_mode_i == MODE_WRITE);
        // compare the 4 KiB page
        in_spm  = (rx_addr_i >> `REGION_OFFS_SIZE) == (`SPM_START_ADDR >> `REGION_OFFS_SIZE);
        in_cfg  = (rx_addr_i >> `REGION_OFFS_SIZE) == (`CFG_START_ADDR >> `REGION_OFFS_SIZE);
        accept  = tgt_hit && mode_ok && (in_spm || in_cfg);
    end

    always_ff @(posedge clk_pm_i) begin
        if (reset_i) begin
            req_o.valid <= 1'b0;
            drop_o      <= 1'b0;
        end else if (!hold_i) begin
            req_o.valid <= rx_wrreq_i && accept;
            drop_o      <= rx_wrreq_i && !accept;  // counted downstream
        end
    end

    always_ff @(posedge clk_pm_i) begin
        if (!hold_i && rx_wrreq_i) begin
            req_o.mode        <= noc_mode_e'(rx_mode_i);
            req_o.region      <= in_cfg ? REGION_CFG : REGION_SPM;
            req_o.addr        <= rx_addr_i;
            req_o.data        <= rx_data_i;
            req_o.peer_chipid <= rx_src_chipid_i;
            req_o.peer_modid  <= rx_src_modid_i;
        end
    end

    a_mode_known: assert property (@(posedge clk_pm_i) disable iff (reset_i)
        rx_wrreq_i |-> !$isunknown(rx_mode_i));

endmodule

// File: hdl/mem_access_stage.sv
`include "pm_tile_consts.svh"

module mem_access_stage (
    input  logic       clk_pm_i,
    input  logic       reset_i,
    input  logic       hold_i,
    noc_req_if.dst     req_i,
    input  logic       drop_i,
    noc_req_if.src     resp_o,
    output logic       core_en_o,
    output logic [1:0] ext_int_o
);
    import pm_tile_pkg::*;

    logic                      is_write;
    logic                      spm_sel;
    logic                      cfg_sel;
    logic [`NOC_DATA_SIZE-1:0] spm_rdata;
    logic [`NOC_DATA_SIZE-1:0] cfg_rdata;

    assign is_write = (req_i.mode == MODE_WRITE);
    assign spm_sel  = req_i.valid && !hold_i && (req_i.region == REGION_SPM);
    assign cfg_sel  = req_i.valid && !hold_i && (req_i.region == REGION_CFG);

    spm u_spm (
        .clk_pm_i (clk_pm_i),
        .en_i     (spm_sel),
        .we_i     (is_write),
        .addr_i   (req_i.addr[`SPM_ADDR_SIZE+2:3]),  // byte to word index
        .wdata_i  (req_i.data),
        .rdata_o  (spm_rdata)
    );

    tile_regfile u_regfile (
        .clk_pm_i  (clk_pm_i),
        .reset_i   (reset_i),
        .en_i      (cfg_sel),
        .we_i      (is_write),
        .addr_i    (req_i.addr[`REGION_OFFS_SIZE-1:0]),
        .wdata_i   (req_i.data),
        .rdata_o   (cfg_rdata),
        .drop_i    (drop_i && !hold_i),  // once per dropped packet
        .core_en_o (core_en_o),
        .ext_int_o (ext_int_o)
    );

    always_ff @(posedge clk_pm_i) begin
        if (reset_i) begin
            resp_o.valid <= 1'b0;
        end else if (!hold_i) begin
            resp_o.valid <= req_i.valid && (req_i.mode == MODE_READ_REQ);
        end
    end

    always_ff @(posedge clk_pm_i) begin
        if (!hold_i && req_i.valid) begin
            resp_o.mode        <= req_i.mode;
            resp_o.region      <= req_i.region;
            resp_o.addr        <= req_i.addr;
            resp_o.peer_chipid <= req_i.peer_chipid;
            resp_o.peer_modid  <= req_i.peer_modid;
        end
    end

    // both units keep their read word until the next access
    assign resp_o.data = (resp_o.region == REGION_CFG) ? cfg_rdata : spm_rdata;

endmodule

// File: hdl/noc_tx_encode.sv
`include "pm_tile_consts.svh"

module noc_tx_encode (
    input  logic                        clk_pm_i,
    input  logic                        reset_i,
    input  logic                        tx_stall_i,
    noc_req_if.dst                      resp_i,
    output logic                        tx_wrreq_o,
    output logic [`NOC_MODE_SIZE-1:0]   tx_mode_o,
    output logic [`NOC_ADDR_SIZE-1:0]   tx_addr_o,
    output logic [`NOC_DATA_SIZE-1:0]   tx_data_o,
    output logic [`NOC_CHIPID_SIZE-1:0] tx_trg_chipid_o,
    output logic [`NOC_MODID_SIZE-1:0]  tx_trg_modid_o,
    output logic                        rx_stall_o
);
    import pm_tile_pkg::*;

    logic advance;

    // whole pipeline moves unless a packet waits on the stall
    assign advance    = !(tx_wrreq_o && tx_stall_i);
    assign rx_stall_o = !advance;

    always_ff @(posedge clk_pm_i) begin
        if (reset_i) begin
            tx_wrreq_o <= 1'b0;
        end else if (advance) begin
            tx_wrreq_o <= resp_i.valid && (resp_i.mode == MODE_READ_REQ);
        end
    end

    always_ff @(posedge clk_pm_i) begin
        if (advance && resp_i.valid) begin
            tx_mode_o       <= MODE_READ_RESP;
            tx_addr_o       <= resp_i.addr;
            tx_data_o       <= resp_i.data;
            tx_trg_chipid_o <= resp_i.peer_chipid;  // back to requester
            tx_trg_modid_o  <= resp_i.peer_modid;
        end
    end

    // the response queued behind a stalled packet must not move
    a_hold_stable: assert property (@(posedge clk_pm_i) disable iff (reset_i)
        (tx_wrreq_o && tx_stall_i) |=> $stable({resp_i.valid, resp_i.addr, resp_i.data,
            resp_i.peer_chipid, resp_i.peer_modid}));

endmodule

// File: hdl/pm_tile.sv
`include "pm_tile_consts.svh"

module pm_tile #(
    parameter logic [`NOC_MODID_SIZE-1:0] HOME_MODID = '0
) (
    input  logic                        clk_pm_i,
    input  logic                        reset_i,
    input  logic [`NOC_CHIPID_SIZE-1:0] home_chipid_i,

    input  logic                        rx_wrreq_i,
    input  logic [`NOC_MODE_SIZE-1:0]   rx_mode_i,
    input  logic [`NOC_ADDR_SIZE-1:0]   rx_addr_i,
    input  logic [`NOC_DATA_SIZE-1:0]   rx_data_i,
    input  logic [`NOC_CHIPID_SIZE-1:0] rx_src_chipid_i,
    input  logic [`NOC_MODID_SIZE-1:0]  rx_src_modid_i,
    input  logic [`NOC_CHIPID_SIZE-1:0] rx_trg_chipid_i,
    input  logic [`NOC_MODID_SIZE-1:0]  rx_trg_modid_i,
    output logic                        rx_stall_o,

    output logic                        tx_wrreq_o,
    output logic [`NOC_MODE_SIZE-1:0]   tx_mode_o,
    output logic [`NOC_ADDR_SIZE-1:0]   tx_addr_o,
    output logic [`NOC_DATA_SIZE-1:0]   tx_data_o,
    output logic [`NOC_CHIPID_SIZE-1:0] tx_trg_chipid_o,
    output logic [`NOC_MODID_SIZE-1:0]  tx_trg_modid_o,
    input  logic                        tx_stall_i,

    output logic                        core_en_o,
    output logic [1:0]                  ext_int_o
);

    logic drop_s;

    noc_req_if dec2acc ();
    noc_req_if acc2tx ();

    noc_rx_decode #(
        .HOME_MODID (HOME_MODID)
    ) u_rx_decode (
        .clk_pm_i        (clk_pm_i),
        .reset_i         (reset_i),
        .hold_i          (rx_stall_o),  // global stall from tx
        .home_chipid_i   (home_chipid_i),
        .rx_wrreq_i      (rx_wrreq_i),
        .rx_mode_i       (rx_mode_i),
        .rx_addr_i       (rx_addr_i),
        .rx_data_i       (rx_data_i),
        .rx_src_chipid_i (rx_src_chipid_i),
        .rx_src_modid_i  (rx_src_modid_i),
        .rx_trg_chipid_i (rx_trg_chipid_i),
        .rx_trg_modid_i  (rx_trg_modid_i),
        .req_o           (dec2acc),
        .drop_o          (drop_s)
    );

    mem_access_stage u_mem_access (
        .clk_pm_i  (clk_pm_i),
        .reset_i   (reset_i),
        .hold_i    (rx_stall_o),
        .req_i     (dec2acc),
        .drop_i    (drop_s),
        .resp_o    (acc2tx),
        .core_en_o (core_en_o),
        .ext_int_o (ext_int_o)
    );

    noc_tx_encode u_tx_encode (
        .clk_pm_i        (clk_pm_i),
        .reset_i         (reset_i),
        .tx_stall_i      (tx_stall_i),
        .resp_i          (acc2tx),
        .tx_wrreq_o      (tx_wrreq_o),
        .tx_mode_o       (tx_mode_o),
        .tx_addr_o       (tx_addr_o),
        .tx_data_o       (tx_data_o),
        .tx_trg_chipid_o (tx_trg_chipid_o),
        .tx_trg_modid_o  (tx_trg_modid_o),
        .rx_stall_o      (rx_stall_o)
    );

endmodule

// File: dv/pm_tile_tb.sv
`include "pm_tile_consts.svh"

module pm_tile_tb;
    import pm_tile_pkg::*;

    localparam logic [7:0] HOME_CHIP = 8'h3c;
    localparam logic [7:0] HOME_MOD  = 8'h05;
    localparam int NUM_SPM     = 16;
    localparam int NUM_BP      = 24;
    localparam int NUM_PACKETS = 72;

    logic        clk;
    logic        reset;
    logic [7:0]  home_chip;
    logic        rx_wrreq;
    logic [3:0]  rx_mode;
    logic [31:0] rx_addr;
    logic [63:0] rx_data;
    logic [7:0]  rx_src_chip;
    logic [7:0]  rx_src_mod;
    logic [7:0]  rx_trg_chip;
    logic [7:0]  rx_trg_mod;
    logic        rx_stall;
    logic        tx_wrreq;
    logic [3:0]  tx_mode;
    logic [31:0] tx_addr;
    logic [63:0] tx_data;
    logic [7:0]  tx_trg_chip;
    logic [7:0]  tx_trg_mod;
    logic        tx_stall;
    logic        core_en;
    logic [1:0]  ext_int;

    integer seed = 46;
    int     cycle = 0;
    int     mismatches = 0;
    int     failures = 0;
    bit     check_latency = 0;
    bit     stall_en = 0;

    // reference state
    logic [63:0] model_spm [0:511];
    logic        model_core_en = 1'b0;
    logic [1:0]  model_ext_int = 2'b00;
    logic [31:0] model_drop_cnt = '0;
    logic [8:0]  wr_idx [0:NUM_SPM-1];

    // expected responses, oldest first
    logic [31:0] exp_addr_q [$];
    logic [63:0] exp_data_q [$];
    logic [7:0]  exp_chip_q [$];
    logic [7:0]  exp_mod_q [$];
    int          exp_edge_q [$];

    pm_tile #(
        .HOME_MODID (HOME_MOD)
    ) DUT (
        .clk_pm_i        (clk),
        .reset_i         (reset),
        .home_chipid_i   (home_chip),
        .rx_wrreq_i      (rx_wrreq),
        .rx_mode_i       (rx_mode),
        .rx_addr_i       (rx_addr),
        .rx_data_i       (rx_data),
        .rx_src_chipid_i (rx_src_chip),
        .rx_src_modid_i  (rx_src_mod),
        .rx_trg_chipid_i (rx_trg_chip),
        .rx_trg_modid_i  (rx_trg_mod),
        .rx_stall_o      (rx_stall),
        .tx_wrreq_o      (tx_wrreq),
        .tx_mode_o       (tx_mode),
        .tx_addr_o       (tx_addr),
        .tx_data_o       (tx_data),
        .tx_trg_chipid_o (tx_trg_chip),
        .tx_trg_modid_o  (tx_trg_mod),
        .tx_stall_i      (tx_stall),
        .core_en_o       (core_en),
        .ext_int_o       (ext_int)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    always @(posedge clk) begin
        if (stall_en)
            tx_stall <= 1'($random(seed));
        else
            tx_stall <= 1'b0;
    end

    function automatic void model_access(
        input logic [3:0]  mode,
        input logic [31:0] addr,
        input logic [63:0] data,
        input logic [7:0]  src_chip,
        input logic [7:0]  src_mod,
        input logic [7:0]  trg_chip,
        input logic [7:0]  trg_mod,
        input int          acc_edge
    );
        logic        hit;
        logic        in_spm;
        logic        in_cfg;
        logic [63:0] rd;
        hit    = (trg_chip == HOME_CHIP) && (trg_mod == HOME_MOD)
                 && (mode == MODE_READ_REQ || mode == MODE_WRITE);
        in_spm = (addr & 32'hffff_f000) == `SPM_START_ADDR;
        in_cfg = (addr & 32'hffff_f000) == `CFG_START_ADDR;
        rd     = '0;
        if (!hit || !(in_spm || in_cfg)) begin
            if (model_drop_cnt != 32'hffff_ffff)
                model_drop_cnt++;
            return;
        end
        if (in_spm) begin
            if (mode == MODE_WRITE)
                model_spm[addr[11:3]] = data;
            rd = model_spm[addr[11:3]];
        end else begin
            case (addr[11:0])
                `CFG_REG_CORE_EN: begin
                    if (mode == MODE_WRITE)
                        model_core_en = data[0];
                    rd = {63'b0, model_core_en};
                end
                `CFG_REG_EXT_INT: begin
                    if (mode == MODE_WRITE)
                        model_ext_int = data[1:0];
                    rd = {62'b0, model_ext_int};
                end
                `CFG_REG_DROP_CNT: rd = {32'b0, model_drop_cnt};  // writes ignored
                default: rd = '0;
            endcase
        end
        if (mode == MODE_READ_REQ) begin
            exp_addr_q.push_back(addr);
            exp_data_q.push_back(rd);
            exp_chip_q.push_back(src_chip);  // response goes back to the source
            exp_mod_q.push_back(src_mod);
            exp_edge_q.push_back(acc_edge + 3);
        end
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
        mismatches++;
    endtask

    // compare every packet the receiver takes
    always @(negedge clk) begin
        if (!reset && tx_wrreq && !tx_stall) begin
            if (exp_addr_q.size() == 0) begin
                $display("ERROR t=%0t unexpected response with address %h", $time, tx_addr);
                failures++;
            end else begin
                if (tx_mode !== MODE_READ_RESP)
                    report_mismatch("tx_mode_o", MODE_READ_RESP, tx_mode);
                if (tx_addr !== exp_addr_q[0])
                    report_mismatch("tx_addr_o", exp_addr_q[0], tx_addr);
                if (tx_data !== exp_data_q[0])
                    report_mismatch("tx_data_o", exp_data_q[0], tx_data);
                if (tx_trg_chip !== exp_chip_q[0])
                    report_mismatch("tx_trg_chipid_o", exp_chip_q[0], tx_trg_chip);
                if (tx_trg_mod !== exp_mod_q[0])
                    report_mismatch("tx_trg_modid_o", exp_mod_q[0], tx_trg_mod);
                if (check_latency && (cycle + 1 != exp_edge_q[0]))
                    report_mismatch("response edge", exp_edge_q[0], cycle + 1);
                void'(exp_addr_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_chip_q.pop_front());
                void'(exp_mod_q.pop_front());
                void'(exp_edge_q.pop_front());
            end
        end
    end

    // called on a rising edge, returns on the accepting edge
    task automatic send_packet(input logic [3:0] mode, input logic [31:0] addr,
                               input logic [63:0] data, input logic [7:0] src_chip,
                               input logic [7:0] src_mod, input logic [7:0] trg_chip,
                               input logic [7:0] trg_mod);
        bit taken;
        int acc_edge;
        rx_wrreq    <= 1'b1;
        rx_mode     <= mode;
        rx_addr     <= addr;
        rx_data     <= data;
        rx_src_chip <= src_chip;
        rx_src_mod  <= src_mod;
        rx_trg_chip <= trg_chip;
        rx_trg_mod  <= trg_mod;
        do begin
            @(negedge clk);
            taken    = !rx_stall;
            acc_edge = cycle + 1;
            @(posedge clk);
        end while (!taken);
        model_access(mode, addr, data, src_chip, src_mod, trg_chip, trg_mod, acc_edge);
    endtask

    task automatic send_to_tile(input logic [3:0] mode, input logic [31:0] addr,
                                input logic [63:0] data, input logic [7:0] src_chip,
                                input logic [7:0] src_mod);
        send_packet(mode, addr, data, src_chip, src_mod, HOME_CHIP, HOME_MOD);
    endtask

    task automatic wait_drain;
        rx_wrreq <= 1'b0;
        @(negedge clk);
        while (exp_addr_q.size() != 0)
            @(negedge clk);
        @(posedge clk);
    endtask

    task automatic check_cfg_outputs;
        if (core_en !== model_core_en)
            report_mismatch("core_en_o", model_core_en, core_en);
        if (ext_int !== model_ext_int)
            report_mismatch("ext_int_o", model_ext_int, ext_int);
    endtask

    initial begin
        int          i;
        logic [63:0] wdata;
        reset       = 1'b1;
        home_chip   = HOME_CHIP;
        rx_wrreq    = 1'b0;
        rx_mode     = '0;
        rx_addr     = '0;
        rx_data     = '0;
        rx_src_chip = '0;
        rx_src_mod  = '0;
        rx_trg_chip = '0;
        rx_trg_mod  = '0;
        tx_stall    = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        if (tx_wrreq !== 1'b0)
            report_mismatch("tx_wrreq_o", 0, tx_wrreq);
        if (rx_stall !== 1'b0)
            report_mismatch("rx_stall_o", 0, rx_stall);
        if (core_en !== 1'b0)
            report_mismatch("core_en_o", 0, core_en);
        if (ext_int !== 2'b00)
            report_mismatch("ext_int_o", 0, ext_int);
        @(posedge clk);
        send_to_tile(MODE_READ_REQ, `CFG_START_ADDR + `CFG_REG_DROP_CNT, '0, 8'h11, 8'h22);
        wait_drain();

        // spm, back to back without stall
        check_latency = 1'b1;
        for (i = 0; i < NUM_SPM; i++) begin
            wr_idx[i] = 9'($random(seed));
            wdata     = {$random(seed), $random(seed)};
            send_to_tile(MODE_WRITE, `SPM_START_ADDR | {20'h0, wr_idx[i], 3'b000}, wdata,
                         8'($random(seed)), 8'($random(seed)));
        end
        for (i = NUM_SPM - 1; i >= 0; i--)
            send_to_tile(MODE_READ_REQ, `SPM_START_ADDR | {20'h0, wr_idx[i], 3'b000}, '0,
                         8'($random(seed)), 8'($random(seed)));
        wait_drain();

        send_to_tile(MODE_WRITE, `CFG_START_ADDR + `CFG_REG_CORE_EN, 64'h1, 8'h21, 8'h07);
        send_to_tile(MODE_WRITE, `CFG_START_ADDR + `CFG_REG_EXT_INT, 64'hffff_fffe, 8'h21, 8'h07);
        send_to_tile(MODE_READ_REQ, `CFG_START_ADDR + `CFG_REG_CORE_EN, '0, 8'h22, 8'h08);
        send_to_tile(MODE_READ_REQ, `CFG_START_ADDR + `CFG_REG_EXT_INT, '0, 8'h23, 8'h09);
        wait_drain();
        check_cfg_outputs();
        send_to_tile(MODE_WRITE, `CFG_START_ADDR + `CFG_REG_CORE_EN, 64'h2, 8'h24, 8'h0a);
        send_to_tile(MODE_READ_REQ, `CFG_START_ADDR + `CFG_REG_CORE_EN, '0, 8'h25, 8'h0b);
        wait_drain();
        check_cfg_outputs();

        // packets that must be dropped, then counter readback
        send_packet(MODE_READ_REQ, {20'h0, wr_idx[1], 3'b000}, '0, 8'h31, 8'h01,
                    HOME_CHIP ^ 8'h01, HOME_MOD);
        send_packet(MODE_WRITE, {20'h0, wr_idx[0], 3'b000}, 64'hdead_beef_0bad_f00d,
                    8'h32, 8'h02, HOME_CHIP, HOME_MOD + 8'd1);
        send_to_tile(MODE_READ_REQ, 32'h0000_1000, '0, 8'h33, 8'h03);
        send_to_tile(MODE_WRITE, 32'h8000_0040, 64'h1234, 8'h34, 8'h04);
        send_to_tile(MODE_READ_RESP, {20'h0, wr_idx[2], 3'b000}, '0, 8'h35, 8'h05);
        send_to_tile(4'hf, {20'h0, wr_idx[3], 3'b000}, '0, 8'h36, 8'h06);
        send_to_tile(MODE_WRITE, `CFG_START_ADDR + `CFG_REG_DROP_CNT, 64'h55, 8'h37, 8'h07);
        send_to_tile(MODE_READ_REQ, `CFG_START_ADDR + 32'h18, '0, 8'h38, 8'h08);
        send_to_tile(MODE_READ_REQ, `CFG_START_ADDR + `CFG_REG_DROP_CNT, '0, 8'h39, 8'h09);
        wait_drain();

        // random back-pressure from the receiver
        check_latency = 1'b0;
        stall_en <= 1'b1;
        for (i = 0; i < NUM_BP; i++)
            send_to_tile(MODE_READ_REQ, {20'h0, wr_idx[i % NUM_SPM], 3'b000}, '0,
                         8'(i), 8'(i + 100));
        wait_drain();
        stall_en <= 1'b0;

        if (exp_addr_q.size() != 0) begin
            $display("ERROR t=%0t %0d responses never arrived", $time, exp_addr_q.size());
            failures++;
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // watchdog
    initial begin
        repeat (NUM_PACKETS * 12 + 200) @(posedge clk);
        $display("ERROR t=%0t run timed out with %0d responses still missing",
                 $time, exp_addr_q.size());
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: pm_tile.f
+incdir+hdl
hdl/pm_tile_pkg.sv
hdl/noc_req_if.sv
hdl/spm.sv
hdl/tile_regfile.sv
hdl/noc_rx_decode.sv
hdl/mem_access_stage.sv
hdl/noc_tx_encode.sv
hdl/pm_tile.sv
dv/pm_tile_tb.sv

// File: Bender.yml
package:
  name: pm_tile

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pm_tile_pkg.sv
      - hdl/noc_req_if.sv
      - hdl/spm.sv
      - hdl/tile_regfile.sv
      - hdl/noc_rx_decode.sv
      - hdl/mem_access_stage.sv
      - hdl/noc_tx_encode.sv
      - hdl/pm_tile.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/pm_tile_tb.sv
